//--- verilog.f
+incdir+design
design/fft_conv_pkg.sv
design/tile_loader.sv
design/dft4x4_forward.sv
design/spectral_multiply.sv
design/dft4x4_inverse.sv
design/channel_accumulate.sv
design/fft_conv_top.sv
bench/fft_conv_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module fft_conv_tb -f verilog.f
out=$(./obj_dir/Vfft_conv_tb || true)
printf '%s\n' "$out"
# exit status follows the pass search
printf '%s\n' "$out" | grep -qx 'sim passed'

//--- bench/fft_conv_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module fft_conv_tb;
    import fft_conv_pkg::*;

    localparam int TILE_W      = `CONV_CHANNELS * 16 * `CONV_PIXEL_W;
    localparam int KERN_W      = `CONV_CHANNELS * 9 * `CONV_WEIGHT_W;
    localparam int OUT_W       = 4 * `CONV_RESULT_W;
    localparam int DONE_EDGE   = 7;
    // 12 reset runs of about 20 cycles plus the hold window and some margin
    localparam int CYCLE_LIMIT = 1000;

    logic              clk = 1'b0;
    logic              reset;
    logic [TILE_W-1:0] in_data;
    logic [KERN_W-1:0] kernel_data;
    logic [OUT_W-1:0]  out_data;
    logic              final_compute;

    // stimulus grids x[ch][row][col] and k[ch][a][b]
    int          x [`CONV_CHANNELS][4][4];
    int          k [`CONV_CHANNELS][3][3];
    logic [31:0] rng_state;
    int          cycles = 0;
    int          errors;
    int          test_errors;
    int          tests_run;

    fft_conv_top i_dut (
        .clk(clk), .reset(reset), .in_data(in_data), .kernel_data(kernel_data),
        .out_data(out_data), .final_compute(final_compute));

    initial begin
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ========================================
    // stimulus helpers
    // ========================================
    function automatic logic [31:0] xorshift_next();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    task automatic fill_random();
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    x[ch][i][j] = int'(pixel_t'(xorshift_next()));
                end
            end
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 3; b++) begin
                    k[ch][a][b] = int'(weight_t'(xorshift_next()));
                end
            end
        end
    endtask

    // flatten with ch 0 row 0 col 0 in the top bits
    task automatic drive_inputs();
        int idx;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    idx = `CONV_CHANNELS * 16 - 1 - (ch * 16 + i * 4 + j);
                    in_data[idx*`CONV_PIXEL_W +: `CONV_PIXEL_W] = pixel_t'(x[ch][i][j]);
                end
            end
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 3; b++) begin
                    idx = `CONV_CHANNELS * 9 - 1 - (ch * 9 + a * 3 + b);
                    kernel_data[idx*`CONV_WEIGHT_W +: `CONV_WEIGHT_W] = weight_t'(k[ch][a][b]);
                end
            end
        end
    endtask

    // ========================================
    // golden model and output access
    // ========================================
    function automatic int golden_conv(int i, int j);
        int sum;
        sum = 0;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 3; b++) begin
                    sum = sum + x[ch][i+2-a][j+2-b] * k[ch][a][b];
                end
            end
        end
        return sum;
    endfunction

    // element (i,j) sits at index i*2+j with (0,0) lowest
    function automatic int out_elem(int idx);
        result_t r;
        r = out_data[idx*`CONV_RESULT_W +: `CONV_RESULT_W];
        return int'(r);
    endfunction

    // ========================================
    // run control
    // ========================================
    // reset for 8 cycles while the outputs stay cleared
    task automatic pulse_reset(string name);
        @(negedge clk);
        reset = 1'b1;
        repeat (8) begin
            @(negedge clk);
            assert (!final_compute && out_data == '0) else begin
                $display("%s: outputs not cleared while reset is high", name);
                test_errors++;
            end
        end
        reset = 1'b0;
    endtask

    // count edges until final_compute while out_data stays zero
    task automatic wait_done(string name);
        int  edges;
        bit  seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 20) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (final_compute) begin
                seen = 1'b1;
            end else begin
                assert (out_data == '0) else begin
                    $display("%s: out_data not zero before final_compute", name);
                    test_errors++;
                end
            end
        end
        assert (seen) else begin
            $display("%s: final_compute never rose", name);
            test_errors++;
        end
        assert (!seen || edges == DONE_EDGE) else begin
            $display("mismatch %s expected %0d actual %0d", name, DONE_EDGE, edges);
            test_errors++;
        end
    endtask

    task automatic check_golden(string name);
        int exp_v;
        int got_v;
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                exp_v = golden_conv(i, j);
                got_v = out_elem(i * 2 + j);
                assert (got_v == exp_v) else begin
                    $display("mismatch %s expected %0d actual %0d", name, exp_v, got_v);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic run_case(string name);
        @(negedge clk);
        drive_inputs();
        pulse_reset(name);
        wait_done(name);
        check_golden(name);
    endtask

    task automatic end_test(string name);
        $display("test %s: %s, %0d errors, stage %s", name,
            (test_errors == 0) ? "ok" : "failed", test_errors, i_dut.stage.name());
        errors      = errors + test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    // ========================================
    // directed tests
    // ========================================
    // done lands on edge 7 and out_data then holds while inputs move
    task automatic done_timing_and_hold();
        logic [OUT_W-1:0] snapshot;
        fill_random();
        run_case("timing_hold");
        snapshot = out_data;
        repeat (10) begin
            fill_random();
            drive_inputs();
            @(negedge clk);
            assert (final_compute) else begin
                $display("timing_hold: final_compute dropped after done");
                test_errors++;
            end
            assert (out_data == snapshot) else begin
                $display("mismatch timing_hold expected %h actual %h", snapshot, out_data);
                test_errors++;
            end
        end
        end_test("timing_hold");
    endtask

    // only k(ch,0,0) is 1 so the result is the shifted tile sum
    task automatic impulse_kernel();
        int exp_v;
        int got_v;
        fill_random();
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 3; b++) begin
                    k[ch][a][b] = (a == 0 && b == 0) ? 1 : 0;
                end
            end
        end
        run_case("impulse");
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                exp_v = 0;
                for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                    exp_v = exp_v + x[ch][i+2][j+2];
                end
                got_v = out_elem(i * 2 + j);
                assert (got_v == exp_v) else begin
                    $display("mismatch impulse expected %0d actual %0d", exp_v, got_v);
                    test_errors++;
                end
            end
        end
        end_test("impulse");
    endtask

    task automatic extreme_values();
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    x[ch][i][j] = -128;
                end
            end
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 3; b++) begin
                    k[ch][a][b] = -128;
                end
            end
        end
        run_case("all_min");
        end_test("all_min");
        // checkerboard of the two extremes
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    x[ch][i][j] = (((ch + i + j) % 2) == 0) ? 127 : -128;
                end
            end
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 3; b++) begin
                    k[ch][a][b] = (((ch + a + b) % 2) == 0) ? 127 : -128;
                end
            end
        end
        run_case("alternating");
        end_test("alternating");
    endtask

    task automatic random_tiles();
        for (int n = 0; n < 8; n++) begin
            fill_random();
            run_case($sformatf("random_%0d", n));
            end_test($sformatf("random_%0d", n));
        end
    endtask

    initial begin
        reset       = 1'b1;
        in_data     = '0;
        kernel_data = '0;
        rng_state   = 32'h75aa;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        done_timing_and_hold();
        impulse_kernel();
        extreme_values();
        random_tiles();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/fft_conv_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module fft_conv_top (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  [`CONV_CHANNELS*16*`CONV_PIXEL_W-1:0] in_data,
    input  wire  [`CONV_CHANNELS*9*`CONV_WEIGHT_W-1:0] kernel_data,
    output fft_conv_pkg::result_t [3:0]                out_data,
    output logic                                       final_compute
);
    import fft_conv_pkg::*;

    spec_grid_t [`CONV_CHANNELS-1:0] tile_re, kern_re;
    spec_grid_t [`CONV_CHANNELS-1:0] tile_spec_re, tile_spec_im;
    spec_grid_t [`CONV_CHANNELS-1:0] kern_spec_re, kern_spec_im;
    spec_grid_t [`CONV_CHANNELS-1:0] prod_re, prod_im;
    spec_grid_t [`CONV_CHANNELS-1:0] conv_re;
    logic load_valid, tile_fwd_valid, kern_fwd_valid;
    logic mult_valid, inv_valid;
    conv_stage_e stage;

    tile_loader i_loader (
        .clk(clk), .reset(reset), .in_data(in_data), .kernel_data(kernel_data),
        .tile_re(tile_re), .kernel_re(kern_re), .load_valid(load_valid));

    // same transform for tile and kernel, running side by side
    dft4x4_forward i_fwd_tile (
        .clk(clk), .reset(reset), .in_valid(load_valid), .in_re(tile_re),
        .out_re(tile_spec_re), .out_im(tile_spec_im), .out_valid(tile_fwd_valid));
    dft4x4_forward i_fwd_kern (
        .clk(clk), .reset(reset), .in_valid(load_valid), .in_re(kern_re),
        .out_re(kern_spec_re), .out_im(kern_spec_im), .out_valid(kern_fwd_valid));

    spectral_multiply i_mult (
        .clk(clk), .reset(reset), .in_valid(tile_fwd_valid & kern_fwd_valid),
        .tile_re(tile_spec_re), .tile_im(tile_spec_im),
        .kern_re(kern_spec_re), .kern_im(kern_spec_im),
        .prod_re(prod_re), .prod_im(prod_im), .out_valid(mult_valid));

    dft4x4_inverse i_inv (
        .clk(clk), .reset(reset), .in_valid(mult_valid), .in_re(prod_re),
        .in_im(prod_im), .out_re(conv_re), .out_valid(inv_valid));

    channel_accumulate i_acc (
        .clk(clk), .reset(reset), .in_valid(inv_valid), .in_re(conv_re),
        .out_data(out_data), .final_compute(final_compute));

    // stage tracker, one step per cycle after reset release
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage <= stage_idle;
        end else if (stage != stage_done) begin
            stage <= conv_stage_e'(stage + 3'd1);
        end
    end

    a_fwd_lockstep: assert property (@(posedge clk) disable iff (reset)
        tile_fwd_valid == kern_fwd_valid);
    // strobes line up with the fixed schedule, done lands on edge 7
    a_inv_on_time: assert property (@(posedge clk) disable iff (reset)
        inv_valid == (stage == stage_inv_col));
    a_done_on_time: assert property (@(posedge clk) disable iff (reset)
        final_compute == (stage == stage_done));

endmodule

`default_nettype wire

//--- design/channel_accumulate.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module channel_accumulate (
    input  wire                                                clk,
    input  wire                                                reset,
    input  wire                                                in_valid,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] in_re,
    output fft_conv_pkg::result_t [3:0]                        out_data,
    output logic                                               final_compute
);
    import fft_conv_pkg::*;

    result_t [3:0] crop_sum;

    // bottom right 2x2 is the valid part of the circular result
    always_comb begin : crop
        spec_t v;
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                crop_sum[i*2+j] = '0;
                for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                    v = in_re[ch][i+2][j+2];
                    crop_sum[i*2+j] = crop_sum[i*2+j] + result_t'(v);
                end
            end
        end
    end

    // element (0,0) in the low bits, result held until next reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_data      <= '0;
            final_compute <= 1'b0;
        end else if (in_valid) begin
            out_data      <= crop_sum;
            final_compute <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/dft4x4_inverse.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module dft4x4_inverse (
    input  wire                                                clk,
    input  wire                                                reset,
    input  wire                                                in_valid,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] in_re,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] in_im,
    output fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0]      out_re,
    output logic                                               out_valid
);
    import fft_conv_pkg::*;

    spec_grid_t [`CONV_CHANNELS-1:0] row_re, row_im;
    spec_grid_t [`CONV_CHANNELS-1:0] row_re_d, row_im_d;
    spec_grid_t [`CONV_CHANNELS-1:0] col_sum, col_sum_d;
    logic                            row_valid;
    logic                            frac_bits;

    // ========================================
    // row pass, conjugate twiddle +j
    // ========================================
    always_comb begin : row_pass
        spec_t ar, ai, br, bi, cr, ci, dr, di;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                ar = in_re[ch][i][0];
                ai = in_im[ch][i][0];
                br = in_re[ch][i][1];
                bi = in_im[ch][i][1];
                cr = in_re[ch][i][2];
                ci = in_im[ch][i][2];
                dr = in_re[ch][i][3];
                di = in_im[ch][i][3];
                row_re_d[ch][i][0] = ar + br + cr + dr;
                row_im_d[ch][i][0] = ai + bi + ci + di;
                // a + jb - c - jd
                row_re_d[ch][i][1] = ar - bi - cr + di;
                row_im_d[ch][i][1] = ai + br - ci - dr;
                row_re_d[ch][i][2] = ar - br + cr - dr;
                row_im_d[ch][i][2] = ai - bi + ci - di;
                row_re_d[ch][i][3] = ar + bi - cr - di;
                row_im_d[ch][i][3] = ai - br - ci + dr;
            end
        end
    end

    // column pass, real part only, still scaled by 16
    always_comb begin : col_pass
        spec_t ar, br, bi, cr, dr, di;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int l = 0; l < 4; l++) begin
                ar = row_re[ch][0][l];
                br = row_re[ch][1][l];
                bi = row_im[ch][1][l];
                cr = row_re[ch][2][l];
                dr = row_re[ch][3][l];
                di = row_im[ch][3][l];
                col_sum_d[ch][0][l] = ar + br + cr + dr;
                col_sum_d[ch][1][l] = ar - bi - cr + di;
                col_sum_d[ch][2][l] = ar - br + cr - dr;
                col_sum_d[ch][3][l] = ar + bi - cr - di;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            row_re <= row_re_d;
            row_im <= row_im_d;
        end
        if (row_valid) begin
            col_sum <= col_sum_d;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            row_valid <= in_valid;
            out_valid <= row_valid;
        end
    end

    // single divide by 16, exact for a true integer convolution
    always_comb begin
        frac_bits = 1'b0;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    out_re[ch][i][j] = $signed(col_sum[ch][i][j]) >>> 4;
                    frac_bits = frac_bits | (|col_sum[ch][i][j][3:0]);
                end
            end
        end
    end

    // whole forward/multiply/inverse chain must land on multiples of 16
    a_exact_scale: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !frac_bits);

endmodule

`default_nettype wire

//--- design/spectral_multiply.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module spectral_multiply (
    input  wire                                                clk,
    input  wire                                                reset,
    input  wire                                                in_valid,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] tile_re,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] tile_im,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] kern_re,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] kern_im,
    output fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0]      prod_re,
    output fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0]      prod_im,
    output logic                                               out_valid
);
    import fft_conv_pkg::*;

    spec_grid_t [`CONV_CHANNELS-1:0] prod_re_d, prod_im_d;

    // three multiplier complex product per bin
    always_comb begin : bin_product
        spec_t tr, ti, kr, ki;
        spec_t p, q, r;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    tr = tile_re[ch][i][j];
                    ti = tile_im[ch][i][j];
                    kr = kern_re[ch][i][j];
                    ki = kern_im[ch][i][j];
                    p  = ti * (kr - ki);
                    q  = kr * (tr - ti);
                    r  = ki * (tr + ti);
                    // p+q = tr*kr - ti*ki, p+r = ti*kr + tr*ki
                    prod_re_d[ch][i][j] = p + q;
                    prod_im_d[ch][i][j] = p + r;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod_re <= prod_re_d;
            prod_im <= prod_im_d;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

//--- design/dft4x4_forward.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module dft4x4_forward (
    input  wire                                           clk,
    input  wire                                           reset,
    input  wire                                           in_valid,
    input  wire fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] in_re,
    output fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] out_re,
    output fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] out_im,
    output logic                                          out_valid
);
    import fft_conv_pkg::*;

    spec_grid_t [`CONV_CHANNELS-1:0] row_re, row_im;
    spec_grid_t [`CONV_CHANNELS-1:0] row_re_d, row_im_d;
    spec_grid_t [`CONV_CHANNELS-1:0] col_re_d, col_im_d;
    logic                            row_valid;

    // ========================================
    // row pass, real input along each row
    // ========================================
    always_comb begin : row_pass
        spec_t x0, x1, x2, x3;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                x0 = in_re[ch][i][0];
                x1 = in_re[ch][i][1];
                x2 = in_re[ch][i][2];
                x3 = in_re[ch][i][3];
                // bins 0 and 2 of a real signal are real
                row_re_d[ch][i][0] = x0 + x1 + x2 + x3;
                row_im_d[ch][i][0] = '0;
                row_re_d[ch][i][1] = x0 - x2;
                row_im_d[ch][i][1] = x3 - x1;
                row_re_d[ch][i][2] = x0 - x1 + x2 - x3;
                row_im_d[ch][i][2] = '0;
                // bin 3 is the conjugate of bin 1
                row_re_d[ch][i][3] = x0 - x2;
                row_im_d[ch][i][3] = x1 - x3;
            end
        end
    end

    // ========================================
    // column pass, complex, twiddle is -j
    // ========================================
    always_comb begin : col_pass
        spec_t ar, ai, br, bi, cr, ci, dr, di;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int l = 0; l < 4; l++) begin
                ar = row_re[ch][0][l];
                ai = row_im[ch][0][l];
                br = row_re[ch][1][l];
                bi = row_im[ch][1][l];
                cr = row_re[ch][2][l];
                ci = row_im[ch][2][l];
                dr = row_re[ch][3][l];
                di = row_im[ch][3][l];
                col_re_d[ch][0][l] = ar + br + cr + dr;
                col_im_d[ch][0][l] = ai + bi + ci + di;
                // a - jb - c + jd
                col_re_d[ch][1][l] = ar + bi - cr - di;
                col_im_d[ch][1][l] = ai - br - ci + dr;
                col_re_d[ch][2][l] = ar - br + cr - dr;
                col_im_d[ch][2][l] = ai - bi + ci - di;
                // a + jb - c - jd
                col_re_d[ch][3][l] = ar - bi - cr + di;
                col_im_d[ch][3][l] = ai + br - ci - dr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            row_re <= row_re_d;
            row_im <= row_im_d;
        end
        if (row_valid) begin
            out_re <= col_re_d;
            out_im <= col_im_d;
        end
    end

    // strobe follows the data through both passes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            row_valid <= in_valid;
            out_valid <= row_valid;
        end
    end

endmodule

`default_nettype wire

//--- design/tile_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "conv_defines.svh"

module tile_loader (
    input  wire                                           clk,
    input  wire                                           reset,
    input  wire  [`CONV_CHANNELS*16*`CONV_PIXEL_W-1:0]    in_data,
    input  wire  [`CONV_CHANNELS*9*`CONV_WEIGHT_W-1:0]    kernel_data,
    output fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] tile_re,
    output fft_conv_pkg::spec_grid_t [`CONV_CHANNELS-1:0] kernel_re,
    output logic                                          load_valid
);
    import fft_conv_pkg::*;

    localparam int TILE_ELEMS = `CONV_CHANNELS * 16;
    localparam int KERN_ELEMS = `CONV_CHANNELS * 9;

    spec_grid_t [`CONV_CHANNELS-1:0] tile_d;
    spec_grid_t [`CONV_CHANNELS-1:0] kern_d;
    logic                            loaded;

    // unflatten both buses, ch 0 row 0 col 0 sits in the top bits
    always_comb begin : unpack
        int tidx;
        int kidx;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    tidx = TILE_ELEMS - 1 - (ch * 16 + i * 4 + j);
                    kidx = KERN_ELEMS - 1 - (ch * 9 + i * 3 + j);
                    tile_d[ch][i][j] = spec_t'(pixel_t'(
                        in_data[tidx*`CONV_PIXEL_W +: `CONV_PIXEL_W]));
                    // 3x3 kernel goes top left, rest of the 4x4 is zero
                    if (i < 3 && j < 3) begin
                        kern_d[ch][i][j] = spec_t'(weight_t'(
                            kernel_data[kidx*`CONV_WEIGHT_W +: `CONV_WEIGHT_W]));
                    end else begin
                        kern_d[ch][i][j] = '0;
                    end
                end
            end
        end
    end

    // one load per reset, loaded blocks anything later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loaded     <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            loaded     <= 1'b1;
            load_valid <= !loaded;
        end
    end

    always_ff @(posedge clk) begin
        if (!loaded) begin
            tile_re   <= tile_d;
            kernel_re <= kern_d;
        end
    end

endmodule

`default_nettype wire

//--- design/fft_conv_pkg.sv
`default_nettype none

`include "conv_defines.svh"

package fft_conv_pkg;

    // raw samples as they arrive on the flattened buses
    typedef logic signed [`CONV_PIXEL_W-1:0] pixel_t;
    typedef logic signed [`CONV_WEIGHT_W-1:0] weight_t;

    // spectral and intermediate value, wide enough for the unscaled inverse
    typedef logic signed [`CONV_SPEC_W-1:0] spec_t;

    // one channel's 4x4 grid, indexed [row][col]
    typedef spec_t [3:0][3:0] spec_grid_t;

    // one output element after crop and channel sum
    typedef logic signed [`CONV_RESULT_W-1:0] result_t;

    // stage whose result was produced on the last clock edge
    typedef enum logic [2:0] {
        stage_idle,
        stage_load,
        stage_fwd_row,
        stage_fwd_col,
        stage_multiply,
        stage_inv_row,
        stage_inv_col,
        stage_done
    } conv_stage_e;

endpackage

`default_nettype wire

//--- design/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// number of input channels summed into one output tile
`define CONV_CHANNELS 3

// input tile sample width, signed
`define CONV_PIXEL_W 8

// kernel sample width, signed
`define CONV_WEIGHT_W 8

// every spectral and intermediate value
// worst case inverse sum needs about 30 bits
`define CONV_SPEC_W 32

// one cropped and channel summed output element
`define CONV_RESULT_W 29

`endif
